//--- source/post_process_defs.svh
`ifndef POST_PROCESS_DEFS_SVH
`define POST_PROCESS_DEFS_SVH

// beat geometry
`define LANES         8
`define INTER_W       16   // partial sum lane width
`define ACT_W         8    // activation after reduction

// shift amounts
`define TRUNC_SHIFT   4
`define LEAKY_SHIFT   6

// storage
`define BIAS_DEPTH    256
`define OUT_DEPTH     32

// intake stops here; the remaining slots absorb
// the beats still in the pipeline and the ready lag
`define OUT_PROG_FULL 24

`endif

//--- source/post_process_pkg.sv
`include "post_process_defs.svh"

package post_process_pkg;

	// one lane and a full beat, lane 0 in the top bits
	typedef logic [`INTER_W-1:0]        lane_t;
	typedef logic [`LANES*`INTER_W-1:0] beat_t;

	typedef logic [`ACT_W-1:0] act_t; // reduced activation

	typedef logic [11:0] dim_t;   // img_h / img_w
	typedef logic [15:0] chan_t;  // o_ch and bias count
	typedef logic [4:0]  group_t; // channel / 8

	typedef logic [31:0] cfg_word_t;

	// controller states, also shown on status
	typedef enum logic [1:0] {
		IDLE      = 2'd0,
		CONFIG    = 2'd1,
		LOAD_BIAS = 2'd2,
		WORK      = 2'd3
	} pp_state_t;

endpackage

//--- source/beat_tag_if.sv
`timescale 1ns/1ps

interface beat_tag_if;
	import post_process_pkg::*;

	logic   fire;       // input beat accepted this cycle
	logic   drop;       // beat is on the filtered first line
	logic   keep;       // even pixel and even line
	group_t group;      // bias read address

	// configuration levels, stable for the whole frame
	logic   relu_en;
	logic   relu_leaky;
	logic   bias_en;
	logic   sample_en;

	modport ctrl (output fire, drop, keep, group, relu_en, relu_leaky, bias_en, sample_en);

	modport pipe (input fire, drop, keep, relu_en, relu_leaky, bias_en, sample_en);

endinterface

//--- source/frame_ctrl.sv
`timescale 1ns/1ps
`include "post_process_defs.svh"

module frame_ctrl (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic                              cfg_valid,
	output logic                              cfg_ready,
	input  post_process_pkg::cfg_word_t       cfg_data,
	input  logic                              bias_valid,
	output logic                              bias_ready,
	output logic                              bias_we,
	output logic [$clog2(`BIAS_DEPTH)-1:0]    bias_waddr,
	input  logic                              in_valid,
	output logic                              in_ready,
	input  logic                              fifo_prog_full,
	beat_tag_if.ctrl                          tag,
	output post_process_pkg::pp_state_t       status
);
	import post_process_pkg::*;

	localparam int GRP_SHIFT = $clog2(`LANES);

	pp_state_t state;
	pp_state_t state_nx;

	// configuration
	logic  relu_en;
	logic  relu_leaky;
	logic  bias_en;
	logic  sample_en;
	logic  row_filter;
	chan_t o_ch;
	dim_t  img_h;
	dim_t  img_w;

	chan_t  bias_cnt;
	dim_t   pix_cnt;
	dim_t   line_cnt;
	group_t grp_cnt;
	logic   in_drop; // still on the discarded first line

	logic cfg_fire;
	logic last_bias;
	logic last_pix;
	logic last_grp;
	logic last_line;
	logic last_beat;

	assign cfg_fire   = cfg_valid & cfg_ready;
	assign bias_we    = bias_valid & bias_ready;
	assign bias_waddr = bias_cnt[$clog2(`BIAS_DEPTH)-1:0];

	assign last_bias = (bias_cnt + chan_t'(1)) == o_ch;
	assign last_pix  = pix_cnt == img_w - dim_t'(1);
	assign last_grp  = chan_t'(grp_cnt) == (o_ch >> GRP_SHIFT) - chan_t'(1);
	assign last_line = line_cnt == img_h - dim_t'(1);
	assign last_beat = last_pix & last_grp & last_line & ~in_drop;

	assign tag.fire       = in_valid & in_ready;
	assign tag.drop       = in_drop;
	assign tag.keep       = ~pix_cnt[0] & ~line_cnt[0];
	assign tag.group      = grp_cnt;
	assign tag.relu_en    = relu_en;
	assign tag.relu_leaky = relu_leaky;
	assign tag.bias_en    = bias_en;
	assign tag.sample_en  = sample_en;

	assign status = state;

	always_comb begin
		state_nx = state;
		case (state)
			IDLE:      if (cfg_fire) state_nx = CONFIG;
			CONFIG:    if (cfg_fire) state_nx = LOAD_BIAS;
			LOAD_BIAS: if (bias_we && last_bias) state_nx = WORK;
			WORK:      if (tag.fire && last_beat) state_nx = IDLE;
			default:   state_nx = IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state      <= IDLE;
			cfg_ready  <= 1'b0;
			bias_ready <= 1'b0;
			in_ready   <= 1'b0;
			relu_en    <= 1'b0;
			relu_leaky <= 1'b0;
			bias_en    <= 1'b0;
			sample_en  <= 1'b0;
			row_filter <= 1'b0;
			o_ch       <= '0;
			img_h      <= '0;
			img_w      <= '0;
			bias_cnt   <= '0;
			pix_cnt    <= '0;
			grp_cnt    <= '0;
			line_cnt   <= '0;
			in_drop    <= 1'b0;
		end else begin
			state <= state_nx;

			// one idle cycle before taking config, so the tail of the
			// last frame still sees the old relu flags
			cfg_ready  <= (state == IDLE || state == CONFIG) &&
				(state_nx == IDLE || state_nx == CONFIG);
			bias_ready <= state_nx == LOAD_BIAS;
			in_ready   <= (state_nx == WORK) && !fifo_prog_full;

			if (cfg_fire && state == IDLE) begin // word 0
				relu_en    <= cfg_data[0];
				relu_leaky <= cfg_data[1];
				bias_en    <= cfg_data[2];
				sample_en  <= cfg_data[3];
				row_filter <= cfg_data[4];
				o_ch       <= cfg_data[23:8];
			end
			if (cfg_fire && state == CONFIG) begin // word 1
				img_h <= cfg_data[23:12];
				img_w <= cfg_data[11:0];
			end

			if (state != LOAD_BIAS) begin
				bias_cnt <= '0;
			end else if (bias_we) begin
				bias_cnt <= bias_cnt + chan_t'(1);
			end

			// pixels innermost, then groups, then lines
			if (state != WORK) begin
				pix_cnt  <= '0;
				grp_cnt  <= '0;
				line_cnt <= '0;
				in_drop  <= row_filter;
			end else if (tag.fire) begin
				if (!last_pix) begin
					pix_cnt <= pix_cnt + dim_t'(1);
				end else begin
					pix_cnt <= '0;
					if (!last_grp) begin
						grp_cnt <= grp_cnt + group_t'(1);
					end else begin
						grp_cnt <= '0;
						if (in_drop) in_drop <= 1'b0; // filtered line does not count
						else line_cnt <= line_cnt + dim_t'(1);
					end
				end
			end
		end
	end

endmodule

//--- source/bias_store.sv
`timescale 1ns/1ps
`include "post_process_defs.svh"

module bias_store (
	input  logic                           clk,
	input  logic                           we,
	input  logic [$clog2(`BIAS_DEPTH)-1:0] waddr,
	input  post_process_pkg::lane_t        wdata,
	input  post_process_pkg::group_t       raddr,
	output post_process_pkg::beat_t        rdata
);
	import post_process_pkg::*;

	localparam int AW = $clog2(`BIAS_DEPTH);

	lane_t         mem [`BIAS_DEPTH];
	logic [AW-1:0] base; // first channel of the group

	assign base = AW'(raddr) << $clog2(`LANES);

	// narrow write side, one channel per bias transfer
	always_ff @(posedge clk) begin
		if (we) mem[waddr] <= wdata;
	end

	// wide read, eight channels of one group, one cycle latency
	always_ff @(posedge clk) begin
		for (int i = 0; i < `LANES; i++) begin
			rdata[(`LANES-1-i)*`INTER_W +: `INTER_W] <= mem[base + AW'(i)];
		end
	end

endmodule

//--- source/lane_pipeline.sv
`timescale 1ns/1ps
`include "post_process_defs.svh"

module lane_pipeline (
	input  logic                    clk,
	input  logic                    rst_n,
	input  post_process_pkg::beat_t in_data,
	beat_tag_if.pipe                tag,
	input  post_process_pkg::beat_t bias,
	output logic                    out_we,
	output post_process_pkg::beat_t out_data
);
	import post_process_pkg::*;

	lane_t lane_in   [`LANES];
	lane_t lane_bias [`LANES];
	lane_t s1 [`LANES]; // after row drop
	lane_t s2 [`LANES]; // after bias
	lane_t s3 [`LANES]; // after relu
	lane_t s4 [`LANES];
	lane_t s5 [`LANES]; // reduced, sign extended

	logic v1;
	logic v2;
	logic v3;
	logic v4;
	logic k1;
	logic k2;
	logic k3;

	// shift, clamp to the activation range, widen back to a lane
	function automatic lane_t reduce(input lane_t x);
		lane_t sh;
		act_t  a;
		sh = lane_t'($signed(x) >>> `TRUNC_SHIFT);
		if (sh[`INTER_W-1:`ACT_W-1] == {(`INTER_W-`ACT_W+1){sh[`INTER_W-1]}}) begin
			a = sh[`ACT_W-1:0];
		end else if (sh[`INTER_W-1]) begin
			a = {1'b1, {(`ACT_W-1){1'b0}}}; // -128
		end else begin
			a = {1'b0, {(`ACT_W-1){1'b1}}}; // 127
		end
		return {{(`INTER_W-`ACT_W){a[`ACT_W-1]}}, a};
	endfunction

	for (genvar i = 0; i < `LANES; i++) begin : g_lane
		assign lane_in[i]   = in_data[(`LANES-1-i)*`INTER_W +: `INTER_W];
		assign lane_bias[i] = bias[(`LANES-1-i)*`INTER_W +: `INTER_W];
		assign s5[i]        = reduce(s4[i]);
		assign out_data[(`LANES-1-i)*`INTER_W +: `INTER_W] = s5[i];
	end

	always_ff @(posedge clk) begin
		for (int i = 0; i < `LANES; i++) begin
			s1[i] <= tag.drop ? '0 : lane_in[i];

			// bias read lands together with s1, 16 bit wrap
			s2[i] <= tag.bias_en ? s1[i] + lane_bias[i] : s1[i];

			if (tag.relu_en && s2[i][`INTER_W-1]) begin
				s3[i] <= tag.relu_leaky ? lane_t'($signed(s2[i]) >>> `LEAKY_SHIFT) : '0;
			end else begin
				s3[i] <= s2[i];
			end

			s4[i] <= s3[i];
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			v1 <= 1'b0;
			v2 <= 1'b0;
			v3 <= 1'b0;
			v4 <= 1'b0;
			k1 <= 1'b0;
			k2 <= 1'b0;
			k3 <= 1'b0;
		end else begin
			v1 <= tag.fire & ~tag.drop;
			k1 <= tag.keep | ~tag.sample_en; // mask taken at intake with the beat
			v2 <= v1;
			k2 <= k1;
			v3 <= v2;
			k3 <= k2;
			v4 <= v3 & k3; // subsample applied here
		end
	end

	assign out_we = v4;

endmodule

//--- source/out_fifo.sv
`timescale 1ns/1ps
`include "post_process_defs.svh"

module out_fifo (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    we,
	input  post_process_pkg::beat_t wdata,
	input  logic                    post_ready,
	output logic                    post_valid,
	output post_process_pkg::beat_t post_data,
	output logic                    prog_full
);
	import post_process_pkg::*;

	localparam int AW = $clog2(`OUT_DEPTH);
	localparam logic [AW:0] DEPTH_L  = `OUT_DEPTH;
	localparam logic [AW:0] THRESH_L = `OUT_PROG_FULL;

	beat_t         mem [`OUT_DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          full;
	logic          wr;
	logic          rd;

	assign full = count == DEPTH_L;
	assign wr   = we & ~full;
	assign rd   = post_valid & post_ready;

	// head entry is always presented
	assign post_valid = count != '0;
	assign post_data  = mem[rd_ptr];
	assign prog_full  = count >= THRESH_L;

	always_ff @(posedge clk) begin
		if (wr) mem[wr_ptr] <= wdata;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end else begin
			if (wr) wr_ptr <= wr_ptr + 1'b1; // power of two depth, wraps
			if (rd) rd_ptr <= rd_ptr + 1'b1;
			case ({wr, rd})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

//--- source/post_process.sv
`timescale 1ns/1ps
`include "post_process_defs.svh"

module post_process (
	input  logic                        clk,
	input  logic                        rst_n,
	input  logic                        cfg_valid,
	output logic                        cfg_ready,
	input  post_process_pkg::cfg_word_t cfg_data,
	input  logic                        bias_valid,
	output logic                        bias_ready,
	input  post_process_pkg::lane_t     bias_data,
	input  logic                        in_valid,
	output logic                        in_ready,
	input  post_process_pkg::beat_t     in_data,
	output logic                        post_valid,
	input  logic                        post_ready,
	output post_process_pkg::beat_t     post_data,
	output post_process_pkg::pp_state_t status
);
	import post_process_pkg::*;

	beat_tag_if tag ();

	logic                           bias_we;
	logic [$clog2(`BIAS_DEPTH)-1:0] bias_waddr;
	beat_t                          bias_rd;   // biases of the current group
	logic                           pipe_we;
	beat_t                          pipe_data;
	logic                           fifo_prog_full;

	frame_ctrl u_frame_ctrl (
		.clk            (clk),
		.rst_n          (rst_n),
		.cfg_valid      (cfg_valid),
		.cfg_ready      (cfg_ready),
		.cfg_data       (cfg_data),
		.bias_valid     (bias_valid),
		.bias_ready     (bias_ready),
		.bias_we        (bias_we),
		.bias_waddr     (bias_waddr),
		.in_valid       (in_valid),
		.in_ready       (in_ready),
		.fifo_prog_full (fifo_prog_full),
		.tag            (tag),
		.status         (status)
	);

	bias_store u_bias_store (
		.clk   (clk),
		.we    (bias_we),
		.waddr (bias_waddr),
		.wdata (bias_data),
		.raddr (tag.group), // group of the beat being accepted
		.rdata (bias_rd)
	);

	lane_pipeline u_lane_pipeline (
		.clk      (clk),
		.rst_n    (rst_n),
		.in_data  (in_data),
		.tag      (tag),
		.bias     (bias_rd),
		.out_we   (pipe_we),
		.out_data (pipe_data)
	);

	out_fifo u_out_fifo (
		.clk        (clk),
		.rst_n      (rst_n),
		.we         (pipe_we),
		.wdata      (pipe_data),
		.post_ready (post_ready),
		.post_valid (post_valid),
		.post_data  (post_data),
		.prog_full  (fifo_prog_full)
	);

endmodule

//--- bench/post_process_assertions.sv
`timescale 1ns/1ps

module post_process_assertions (
	input logic                        clk,
	input logic                        rst_n,
	input logic                        cfg_valid,
	input logic                        cfg_ready,
	input logic                        bias_valid,
	input logic                        bias_ready,
	input logic                        in_valid,
	input logic                        in_ready,
	input logic                        post_valid,
	input logic                        post_ready,
	input post_process_pkg::beat_t     post_data,
	input post_process_pkg::pp_state_t status
);
	import post_process_pkg::*;

	// handshake outputs come out of a reset cycle low
	reset_quiet: assert property (@(posedge clk)
		!rst_n |=> !cfg_ready && !bias_ready && !in_ready && !post_valid)
		else $error("control output high after a reset cycle");

	post_hold: assert property (@(posedge clk) disable iff (!rst_n)
		post_valid && !post_ready |=> post_valid && $stable(post_data))
		else $error("output beat changed or dropped before it was taken");

	cfg_hold: assert property (@(posedge clk) disable iff (!rst_n)
		cfg_valid && !cfg_ready |=> cfg_valid)
		else $error("config valid dropped before transfer");

	bias_hold: assert property (@(posedge clk) disable iff (!rst_n)
		bias_valid && !bias_ready |=> bias_valid)
		else $error("bias valid dropped before transfer");

	in_hold: assert property (@(posedge clk) disable iff (!rst_n)
		in_valid && !in_ready |=> in_valid)
		else $error("input valid dropped before transfer");

	ready_in_work: assert property (@(posedge clk) disable iff (!rst_n)
		status != WORK |-> !in_ready)
		else $error("in_ready high outside the work state");

endmodule

bind post_process post_process_assertions u_assertions (.*);

//--- bench/tb_post_process.sv
`timescale 1ns/1ps
`include "post_process_defs.svh"

module tb_post_process;
	import post_process_pkg::*;

	localparam int NUM_TESTS = 8;

	logic      clk;
	logic      rst_n;
	logic      cfg_valid;
	logic      cfg_ready;
	cfg_word_t cfg_data;
	logic      bias_valid;
	logic      bias_ready;
	lane_t     bias_data;
	logic      in_valid;
	logic      in_ready;
	beat_t     in_data;
	logic      post_valid;
	logic      post_ready;
	beat_t     post_data;
	pp_state_t status;

	// config word 0 and word 1 per frame, the last two run with random post_ready
	cfg_word_t test_w0 [NUM_TESTS] = '{32'h0000_1000, 32'h0000_1004, 32'h0000_0801,
		32'h0000_0803, 32'h0000_1008, 32'h0000_0810, 32'h0000_181f, 32'h0000_2005};
	cfg_word_t test_w1 [NUM_TESTS] = '{32'h0000_3004, 32'h0000_2003, 32'h0000_2004,
		32'h0000_2004, 32'h0000_4005, 32'h0000_3004, 32'h0000_4006, 32'h0000_3005};
	string test_names [NUM_TESTS] = '{"plain", "bias", "relu", "leaky", "subsample",
		"row_filter", "random_ready", "second_frame"};

	lane_t       bias_tab [`BIAS_DEPTH]; // biases of the current frame
	beat_t       exp_q [$];
	beat_t       exp_beat;
	string       cur_test;
	logic        rand_ready;
	logic [31:0] data_seed;
	logic [31:0] ready_seed;
	int          errors;
	int          checks;
	int          out_count;

	post_process u_post_process (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// bias, relu, then shift and clamp to -128..127, per lane
	function automatic beat_t ref_beat(input beat_t b, input cfg_word_t w0, input int grp);
		beat_t              r;
		logic signed [15:0] v;
		logic signed [15:0] sh;
		r = '0;
		for (int i = 0; i < `LANES; i++) begin
			v = b[(`LANES-1-i)*`INTER_W +: `INTER_W];
			if (w0[2]) v = v + bias_tab[grp*`LANES + i]; // wraps at 16 bits
			if (w0[0] && v < 0) v = w0[1] ? v >>> `LEAKY_SHIFT : 16'sd0;
			sh = v >>> `TRUNC_SHIFT;
			if (sh > 16'sd127) sh = 16'sd127;
			else if (sh < -16'sd128) sh = -16'sd128;
			r[(`LANES-1-i)*`INTER_W +: `INTER_W] = sh;
		end
		return r;
	endfunction

	function automatic int frame_beats(input cfg_word_t w0, input cfg_word_t w1);
		int lines;
		lines = int'(w1[23:12]) + int'(w0[4]);
		return lines * (int'(w0[23:8]) / `LANES) * int'(w1[11:0]);
	endfunction

	// ready is registered, so its value here holds until the next edge
	task automatic wait_transfer(input int port);
		logic ok;
		do begin
			ok = (port == 0) ? cfg_ready : (port == 1) ? bias_ready : in_ready;
			@(posedge clk);
			#2;
		end while (!ok);
	endtask

	task automatic run_frame(input int t);
		cfg_word_t w0;
		cfg_word_t w1;
		int        lines;
		int        groups;
		int        line;
		int        exp_count;
		beat_t     b;
		w0         = test_w0[t];
		w1         = test_w1[t];
		cur_test   = test_names[t];
		rand_ready = t >= 6;
		lines      = int'(w1[23:12]) + int'(w0[4]);
		groups     = int'(w0[23:8]) / `LANES;
		exp_count  = 0;
		out_count  = 0;
		cfg_valid  = 1'b1;
		cfg_data   = w0;
		wait_transfer(0);
		cfg_data   = w1;
		wait_transfer(0);
		cfg_valid  = 1'b0;
		bias_valid = 1'b1;
		for (int c = 0; c < groups * `LANES; c++) begin
			data_seed   = lcg_next(data_seed);
			bias_tab[c] = {{6{data_seed[25]}}, data_seed[25:16]};
			bias_data   = bias_tab[c];
			wait_transfer(1);
		end
		bias_valid = 1'b0;
		for (int l = 0; l < lines; l++) begin
			line = l - int'(w0[4]); // -1 on the filtered line
			for (int g = 0; g < groups; g++) begin
				for (int p = 0; p < int'(w1[11:0]); p++) begin
					for (int i = 0; i < `LANES; i++) begin
						data_seed = lcg_next(data_seed);
						b[(`LANES-1-i)*`INTER_W +: `INTER_W] = (data_seed[15:13] == 3'd0) ?
							data_seed[31:16] : {{4{data_seed[27]}}, data_seed[27:16]};
					end
					if (line >= 0 && (!w0[3] || (p % 2 == 0 && line % 2 == 0))) begin
						exp_q.push_back(ref_beat(b, w0, g));
						exp_count++;
					end
					if (rand_ready && data_seed[30]) begin // idle gap between beats
						in_valid = 1'b0;
						@(posedge clk);
						#2;
					end
					in_valid = 1'b1;
					in_data  = b;
					wait_transfer(2);
				end
			end
		end
		in_valid = 1'b0;
		checks++;
		assert (status == IDLE) else begin
			errors++;
			$display("%s: state did not return to idle after the last beat", cur_test);
		end
		while (exp_q.size() != 0) @(posedge clk);
		repeat (8) @(posedge clk);
		#2;
		checks++;
		assert (out_count == exp_count) else begin
			errors++;
			$display("[FAIL] %s beat count expected %0d actual %0d", cur_test, exp_count,
				out_count);
		end
	endtask

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	initial begin
		post_ready = 1'b0;
		ready_seed = 32'h39ee460f;
		forever begin
			@(posedge clk);
			#2;
			ready_seed = lcg_next(ready_seed);
			// mostly stalled, so the fifo climbs past prog_full
			post_ready = rand_ready ? (&ready_seed[31:30]) : 1'b1;
		end
	end

	// output transfers are settled at the falling edge
	always @(negedge clk) begin
		if (rst_n && post_valid && post_ready) begin
			out_count++;
			checks++;
			assert (exp_q.size() != 0) else begin
				errors++;
				$display("%s: output beat arrived with none expected", cur_test);
			end
			if (exp_q.size() != 0) begin
				exp_beat = exp_q.pop_front();
				assert (post_data === exp_beat) else begin
					errors++;
					$display("[FAIL] %s expected %h actual %h", cur_test, exp_beat, post_data);
				end
			end
		end
	end

	initial begin
		int total;
		total = 0;
		for (int t = 0; t < NUM_TESTS; t++) total += frame_beats(test_w0[t], test_w1[t]);
		repeat (total * 20 + 2000) @(posedge clk);
		$display("timeout: frame %s did not finish in %0d cycles", cur_test, total * 20 + 2000);
		$display("Test failed");
		$finish;
	end

	initial begin
		rst_n      = 1'b0;
		cfg_valid  = 1'b0;
		cfg_data   = '0;
		bias_valid = 1'b0;
		bias_data  = '0;
		in_valid   = 1'b0;
		in_data    = '0;
		rand_ready = 1'b0;
		data_seed  = 32'h39ee460f;
		errors     = 0;
		checks     = 0;
		out_count  = 0;
		cur_test   = "reset";
		repeat (8) @(posedge clk);
		#2;
		rst_n = 1'b1;
		for (int t = 0; t < NUM_TESTS; t++) run_frame(t);
		$display("checks %0d errors %0d", checks, errors);
		if (errors == 0) $display("Test passed");
		else $display("Test failed");
		$finish;
	end

endmodule

//--- post_process.f
+incdir+source
source/post_process_pkg.sv
source/beat_tag_if.sv
source/frame_ctrl.sv
source/bias_store.sv
source/lane_pipeline.sv
source/out_fifo.sv
source/post_process.sv
bench/post_process_assertions.sv
bench/tb_post_process.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
	&& verilator --binary --timing --assert -j 0 --top-module tb_post_process -f post_process.f \
	&& ./obj_dir/Vtb_post_process | tee /dev/stderr | grep -q "Test passed" \
	|| { echo "simulation did not pass"; exit 1; }
